// ==== hdl/core_pkg.sv ====
`default_nettype none

package core_pkg;

	// ==============================
	// Host and management bus
	// ==============================

	localparam int HOST_DATA_W = 32;
	localparam int BUS_ADDR_W  = 32;

	// ==============================
	// VGA mode registers
	// ==============================

	localparam int VGA_ADDR_W   = 20;
	localparam int VGA_WIDTH_W  = 9;
	localparam int VGA_STRIDE_W = 9;
	localparam int VGA_HEIGHT_W = 11;

	// Low two flag bits select the pixel depth
	localparam logic [1:0] MODE_24BPP = 2'd3;
	localparam logic [1:0] MODE_16BPP = 2'd2;

	// ==============================
	// Scan-out descriptor
	// ==============================

	localparam int FB_DIM_W    = 12;
	localparam int FB_STRIDE_W = 14;
	localparam int FB_FMT_W    = 5;

	// Framebuffer lives in a fixed window of DDR space
	localparam logic [9:0] FB_BASE_PREFIX = {4'h3, 6'b111110};

	// 24-bit modes always scan a 640 pixel line
	localparam logic [FB_DIM_W-1:0] FB_FIXED_WIDTH = 12'd640;

	localparam logic [2:0] FMT_8BPP_PAL = 3'd3;
	localparam logic [2:0] FMT_16BPP    = 3'd4;
	localparam logic [2:0] FMT_24BPP    = 3'd5;

	// Palette, 6 bits per channel in and 8 bits per channel out
	localparam int PAL_IN_W   = 18;
	localparam int PAL_OUT_W  = 24;
	localparam int PAL_ADDR_W = 8;

	// Roughly 50 ms at the system clock
	localparam int LED_HOLD_CYCLES = 4500000;

endpackage

`default_nettype wire

// ==== hdl/activity_led.sv ====
`timescale 1ns/1ps
`default_nettype none

module activity_led
	import core_pkg::*;
#(
	parameter int hold_cycles = LED_HOLD_CYCLES
)
(
	input  logic clk_sys,
	input  logic cpu_reset,
	input  logic activity,
	output logic led
);

	localparam int CNT_W = $clog2(hold_cycles + 1);

	logic [CNT_W-1:0] count;

	// Counter keeps reloading for as long as the activity lasts
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			count <= '0;
			led   <= 1'b0;
		end else begin
			if (count == '0) begin
				led <= 1'b0;
			end else begin
				count <= count - 1'b1;
				led   <= 1'b1;
			end

			if (activity)
				count <= CNT_W'(hold_cycles);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/mgmt_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module mgmt_bridge
	import core_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   cpu_reset,
	input  logic                   host_rd,
	input  logic                   host_wr,
	input  logic                   bus_wait,
	input  logic                   bus_rdata_valid,
	input  logic [HOST_DATA_W-1:0] bus_rdata,
	output logic                   io_wait,
	output logic [HOST_DATA_W-1:0] host_rdata,
	output logic                   bus_rd,
	output logic                   bus_we
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ISSUE_RD,
		ST_AWAIT_DATA,
		ST_ISSUE_WR,
		ST_FINISH
	} state_t;

	state_t state;
	logic   rd_done;

	// Read completes once the returned word is seen outside a stall
	assign rd_done = (state == ST_AWAIT_DATA) && !bus_wait && bus_rdata_valid;

	// ==============================
	// Request sequencer
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			state   <= ST_IDLE;
			io_wait <= 1'b0;
			bus_rd  <= 1'b0;
			bus_we  <= 1'b0;
		end else if (state == ST_IDLE) begin
			// Write takes priority when both strobes arrive together
			if (host_wr) begin
				state   <= ST_ISSUE_WR;
				io_wait <= 1'b1;
			end else if (host_rd) begin
				state   <= ST_ISSUE_RD;
				io_wait <= 1'b1;
			end
		end else if (!bus_wait) begin
			// Commands last one accepted cycle
			bus_rd <= 1'b0;
			bus_we <= 1'b0;

			case (state)
				ST_ISSUE_RD: begin
					bus_rd <= 1'b1;
					state  <= ST_AWAIT_DATA;
				end
				ST_AWAIT_DATA: begin
					if (bus_rdata_valid) begin
						io_wait <= 1'b0;
						state   <= ST_IDLE;
					end
				end
				ST_ISSUE_WR: begin
					bus_we <= 1'b1;
					state  <= ST_FINISH;
				end
				ST_FINISH: begin
					io_wait <= 1'b0;
					state   <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
		// While bus_wait is high everything above holds its value
	end

	// Returned word for the host
	always_ff @(posedge clk_sys) begin
		if (rd_done)
			host_rdata <= bus_rdata;
	end

endmodule

`default_nettype wire

// ==== hdl/framebuffer_config.sv ====
`timescale 1ns/1ps
`default_nettype none

module framebuffer_config
	import core_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    cpu_reset,
	input  logic [VGA_ADDR_W-1:0]   vga_start_addr,
	input  logic [VGA_WIDTH_W-1:0]  vga_width,
	input  logic [VGA_STRIDE_W-1:0] vga_stride,
	input  logic [VGA_HEIGHT_W-1:0] vga_height,
	input  logic [3:0]              vga_flags,
	input  logic                    vga_off,
	input  logic                    cfg_rgb_order,
	input  logic                    cfg_565,
	input  logic [PAL_ADDR_W-1:0]   vga_pal_a,
	input  logic [PAL_IN_W-1:0]     vga_pal_d,
	input  logic                    vga_pal_we,
	output logic                    fb_en,
	output logic [31:0]             fb_base,
	output logic [FB_DIM_W-1:0]     fb_width,
	output logic [FB_DIM_W-1:0]     fb_height,
	output logic [FB_STRIDE_W-1:0]  fb_stride,
	output logic [FB_FMT_W-1:0]     fb_format,
	output logic                    fb_force_blank,
	output logic [PAL_ADDR_W-1:0]   fb_pal_addr,
	output logic [PAL_OUT_W-1:0]    fb_pal_dout,
	output logic                    fb_pal_wr
);

	logic [1:0] mode;
	logic [2:0] fmt_code;

	// Widen a 6-bit channel by repeating its top bits into the LSBs
	function automatic logic [7:0] expand6(input logic [5:0] c);
		return {c, c[5:4]};
	endfunction

	assign mode = vga_flags[1:0];

	always_comb begin
		if (mode == MODE_24BPP)
			fmt_code = FMT_24BPP;
		else if (mode == MODE_16BPP)
			fmt_code = FMT_16BPP;
		else
			fmt_code = FMT_8BPP_PAL;
	end

	// ==============================
	// Descriptor register stage
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			fb_en          <= 1'b0;
			fb_force_blank <= 1'b0;
		end else begin
			// Flag bit 2 means text or planar mode, no linear scan-out
			fb_en          <= ~vga_flags[2] && (mode != 2'd0);
			fb_force_blank <= vga_off;
		end
	end

	always_ff @(posedge clk_sys) begin
		fb_base <= {FB_BASE_PREFIX, vga_start_addr, 2'b00};

		if (mode == MODE_24BPP)
			fb_width <= FB_FIXED_WIDTH;
		else if (vga_flags[2])
			fb_width <= FB_DIM_W'({vga_width, 2'b00});
		else
			fb_width <= FB_DIM_W'({vga_width, 3'b000});

		fb_stride <= FB_STRIDE_W'({vga_stride, 3'b000});

		// Line doubling halves the scanned height
		if (vga_flags[3])
			fb_height <= FB_DIM_W'(vga_height[VGA_HEIGHT_W-1:1]);
		else
			fb_height <= FB_DIM_W'(vga_height);

		fb_format <= {~cfg_rgb_order, ~cfg_565, fmt_code};
	end

	// Palette path is combinational
	assign fb_pal_addr = vga_pal_a;
	assign fb_pal_wr   = vga_pal_we;
	assign fb_pal_dout = {expand6(vga_pal_d[17:12]),
	                      expand6(vga_pal_d[11:6]),
	                      expand6(vga_pal_d[5:0])};

endmodule

`default_nettype wire

// ==== hdl/core_host_glue.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_host_glue
	import core_pkg::*;
#(
	parameter int led_hold_cycles = LED_HOLD_CYCLES
)
(
	input  logic                    clk_sys,
	input  logic                    cpu_reset,
	input  logic                    host_rd,
	input  logic                    host_wr,
	input  logic [BUS_ADDR_W-1:0]   host_addr,
	input  logic [HOST_DATA_W-1:0]  host_wdata,
	input  logic                    disk_device,
	input  logic                    bus_wait,
	input  logic                    bus_rdata_valid,
	input  logic [HOST_DATA_W-1:0]  bus_rdata,
	input  logic [VGA_ADDR_W-1:0]   vga_start_addr,
	input  logic [VGA_WIDTH_W-1:0]  vga_width,
	input  logic [VGA_STRIDE_W-1:0] vga_stride,
	input  logic [VGA_HEIGHT_W-1:0] vga_height,
	input  logic [3:0]              vga_flags,
	input  logic                    vga_off,
	input  logic                    cfg_rgb_order,
	input  logic                    cfg_565,
	input  logic [PAL_ADDR_W-1:0]   vga_pal_a,
	input  logic [PAL_IN_W-1:0]     vga_pal_d,
	input  logic                    vga_pal_we,
	output logic                    io_wait,
	output logic [HOST_DATA_W-1:0]  host_rdata,
	output logic                    bus_rd,
	output logic                    bus_we,
	output logic [BUS_ADDR_W-1:0]   bus_addr,
	output logic [HOST_DATA_W-1:0]  bus_wdata,
	output logic                    fb_en,
	output logic [31:0]             fb_base,
	output logic [FB_DIM_W-1:0]     fb_width,
	output logic [FB_DIM_W-1:0]     fb_height,
	output logic [FB_STRIDE_W-1:0]  fb_stride,
	output logic [FB_FMT_W-1:0]     fb_format,
	output logic                    fb_force_blank,
	output logic [PAL_ADDR_W-1:0]   fb_pal_addr,
	output logic [PAL_OUT_W-1:0]    fb_pal_dout,
	output logic                    fb_pal_wr,
	output logic                    led_hdd,
	output logic                    led_fdd
);

	logic hdd_active;
	logic fdd_active;

	// Host holds address and data until io_wait drops
	assign bus_addr  = host_addr;
	assign bus_wdata = host_wdata;

	// Busy time is charged to whichever drive the request targets
	assign hdd_active = disk_device & io_wait;
	assign fdd_active = ~disk_device & io_wait;

	// ==============================
	// Management bridge
	// ==============================

	mgmt_bridge u_bridge (
		.clk_sys         (clk_sys),
		.cpu_reset       (cpu_reset),
		.host_rd         (host_rd),
		.host_wr         (host_wr),
		.bus_wait        (bus_wait),
		.bus_rdata_valid (bus_rdata_valid),
		.bus_rdata       (bus_rdata),
		.io_wait         (io_wait),
		.host_rdata      (host_rdata),
		.bus_rd          (bus_rd),
		.bus_we          (bus_we)
	);

	// ==============================
	// Video descriptor
	// ==============================

	framebuffer_config u_fb_cfg (
		.clk_sys        (clk_sys),
		.cpu_reset      (cpu_reset),
		.vga_start_addr (vga_start_addr),
		.vga_width      (vga_width),
		.vga_stride     (vga_stride),
		.vga_height     (vga_height),
		.vga_flags      (vga_flags),
		.vga_off        (vga_off),
		.cfg_rgb_order  (cfg_rgb_order),
		.cfg_565        (cfg_565),
		.vga_pal_a      (vga_pal_a),
		.vga_pal_d      (vga_pal_d),
		.vga_pal_we     (vga_pal_we),
		.fb_en          (fb_en),
		.fb_base        (fb_base),
		.fb_width       (fb_width),
		.fb_height      (fb_height),
		.fb_stride      (fb_stride),
		.fb_format      (fb_format),
		.fb_force_blank (fb_force_blank),
		.fb_pal_addr    (fb_pal_addr),
		.fb_pal_dout    (fb_pal_dout),
		.fb_pal_wr      (fb_pal_wr)
	);

	// ==============================
	// Drive activity LEDs
	// ==============================

	activity_led #(.hold_cycles(led_hold_cycles)) u_led_hdd (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.activity  (hdd_active),
		.led       (led_hdd)
	);

	activity_led #(.hold_cycles(led_hold_cycles)) u_led_fdd (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.activity  (fdd_active),
		.led       (led_fdd)
	);

endmodule

`default_nettype wire

// ==== test/mgmt_bridge_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module mgmt_bridge_chk (
	input wire logic clk_sys,
	input wire logic cpu_reset,
	input wire logic io_wait,
	input wire logic bus_rd,
	input wire logic bus_we,
	input wire logic bus_wait
);

	// Read by the testbench at the end of the run
	int fail_count = 0;

	// Only one command kind at a time
	assert property (@(posedge clk_sys) disable iff (cpu_reset)
		!(bus_rd && bus_we))
	else begin
		$error("bus_rd and bus_we asserted together");
		fail_count++;
	end

	// A command only exists inside a host transaction
	assert property (@(posedge clk_sys) disable iff (cpu_reset)
		(bus_rd || bus_we) |-> io_wait)
	else begin
		$error("bus command asserted while io_wait is low");
		fail_count++;
	end

	// Back-pressure holds the command as it is
	assert property (@(posedge clk_sys) disable iff (cpu_reset)
		(bus_wait && (bus_rd || bus_we)) |=> (bus_rd == $past(bus_rd) && bus_we == $past(bus_we)))
	else begin
		$error("bus command changed while bus_wait was high");
		fail_count++;
	end

endmodule

bind mgmt_bridge mgmt_bridge_chk u_chk (
	.clk_sys  (clk_sys),
	.cpu_reset(cpu_reset),
	.io_wait  (io_wait),
	.bus_rd   (bus_rd),
	.bus_we   (bus_we),
	.bus_wait (bus_wait)
);

`default_nettype wire

// ==== test/core_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_monitor (
	input  wire logic        clk_sys,
	input  wire logic        io_wait,
	input  wire logic [31:0] host_rdata,
	input  wire logic        bus_rd,
	input  wire logic        bus_we,
	input  wire logic        bus_wait,
	input  wire logic [31:0] bus_addr,
	input  wire logic [31:0] bus_wdata,
	input  wire logic        fb_en,
	input  wire logic [31:0] fb_base,
	input  wire logic [11:0] fb_width,
	input  wire logic [11:0] fb_height,
	input  wire logic [13:0] fb_stride,
	input  wire logic [4:0]  fb_format,
	input  wire logic        fb_force_blank,
	input  wire logic [7:0]  fb_pal_addr,
	input  wire logic [23:0] fb_pal_dout,
	input  wire logic        fb_pal_wr,
	input  wire logic        led_hdd,
	input  wire logic        led_fdd,
	output int               error_count
);

	int          rd_total = 0;
	int          we_total = 0;
	int          hdd_total = 0;
	int          fdd_total = 0;
	int          rd_base, we_base, hdd_base, fdd_base;
	int          test_errs, tests, bad_tests;
	logic [31:0] cap_addr, cap_data;
	string       cur_name;

	initial begin
		error_count = 0;
		tests = 0;
		bad_tests = 0;
	end

	// Accepted commands and LED on-time, sampled before the edge updates
	always @(posedge clk_sys) begin
		if (bus_rd && !bus_wait)
			rd_total <= rd_total + 1;
		if (bus_we && !bus_wait) begin
			we_total <= we_total + 1;
			cap_addr <= bus_addr;
			cap_data <= bus_wdata;
		end
		if (led_hdd)
			hdd_total <= hdd_total + 1;
		if (led_fdd)
			fdd_total <= fdd_total + 1;
	end

	task automatic compare(input string field, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0d ns: %s %s is %h, expected %h",
				$time, cur_name, field, got, exp);
			test_errs++;
			error_count++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("%s: %s", cur_name, msg);
		test_errs++;
		error_count++;
	endtask

	task automatic start_test(input string name);
		cur_name = name;
		test_errs = 0;
		rd_base = rd_total;
		we_base = we_total;
		hdd_base = hdd_total;
		fdd_base = fdd_total;
	endtask

	task automatic end_test();
		tests++;
		if (test_errs != 0)
			bad_tests++;
		$display("test %0d %s: %s", tests, cur_name, (test_errs == 0) ? "ok" : "MISMATCH");
	endtask

	task automatic check_reset();
		compare("io_wait", 32'(io_wait), 32'd0);
		compare("bus_rd", 32'(bus_rd), 32'd0);
		compare("bus_we", 32'(bus_we), 32'd0);
		compare("fb_en", 32'(fb_en), 32'd0);
		compare("led_hdd", 32'(led_hdd), 32'd0);
		compare("led_fdd", 32'(led_fdd), 32'd0);
	endtask

	task automatic check_read(input logic [31:0] exp_data);
		compare("accepted reads", 32'(rd_total - rd_base), 32'd1);
		compare("accepted writes", 32'(we_total - we_base), 32'd0);
		compare("host_rdata", host_rdata, exp_data);
	endtask

	task automatic check_write(input logic [31:0] exp_addr, input logic [31:0] exp_data);
		compare("accepted writes", 32'(we_total - we_base), 32'd1);
		compare("accepted reads", 32'(rd_total - rd_base), 32'd0);
		compare("bus_addr", cap_addr, exp_addr);
		compare("bus_wdata", cap_data, exp_data);
	endtask

	// Only the LED of the addressed drive may have lit
	task automatic check_leds(input logic dev);
		compare("led_hdd lit", 32'(hdd_total != hdd_base), 32'(dev));
		compare("led_fdd lit", 32'(fdd_total != fdd_base), 32'(!dev));
	endtask

	task automatic check_desc(input logic en, input logic [31:0] base, input logic [11:0] w,
			input logic [11:0] h, input logic [13:0] stride, input logic [4:0] fmt,
			input logic blank);
		compare("fb_en", 32'(fb_en), 32'(en));
		compare("fb_base", fb_base, base);
		compare("fb_width", 32'(fb_width), 32'(w));
		compare("fb_height", 32'(fb_height), 32'(h));
		compare("fb_stride", 32'(fb_stride), 32'(stride));
		compare("fb_format", 32'(fb_format), 32'(fmt));
		compare("fb_force_blank", 32'(fb_force_blank), 32'(blank));
	endtask

	task automatic check_pal(input logic [7:0] addr, input logic [23:0] dout);
		compare("fb_pal_addr", 32'(fb_pal_addr), 32'(addr));
		compare("fb_pal_dout", 32'(fb_pal_dout), 32'(dout));
		compare("fb_pal_wr", 32'(fb_pal_wr), 32'd1);
	endtask

	task automatic report();
		$display("tests %0d, ok %0d, with errors %0d, total errors %0d",
			tests, tests - bad_tests, bad_tests, error_count);
	endtask

endmodule

`default_nettype wire

// ==== test/tb_core_host_glue.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core_host_glue;

	localparam int K_RD   = 0;
	localparam int K_WR   = 1;
	localparam int K_DESC = 2;
	localparam int K_PAL  = 3;
	localparam int N_ROWS = 11;
	localparam int WAIT_LIMIT = 200;
	localparam int LED_LIMIT  = 23;

	typedef struct {
		int          kind;
		logic [31:0] a;
		logic [31:0] d;
		logic        dev;
		logic [8:0]  width;
		logic [8:0]  stride;
		logic [10:0] height;
		logic [3:0]  flags;
		logic        off;
		logic        rgb;
		logic        c565;
		logic        e_en;
		logic [31:0] e_base;
		logic [11:0] e_w;
		logic [11:0] e_h;
		logic [13:0] e_stride;
		logic [4:0]  e_fmt;
		logic [23:0] e_pal;
	} row_t;

	logic        clk_sys = 1'b0;
	logic        cpu_reset;
	logic        host_rd, host_wr, disk_device;
	logic [31:0] host_addr, host_wdata;
	logic        bus_wait = 1'b0;
	logic        bus_rdata_valid = 1'b0;
	logic [31:0] bus_rdata = 32'h0;
	logic [19:0] vga_start_addr;
	logic [8:0]  vga_width, vga_stride;
	logic [10:0] vga_height;
	logic [3:0]  vga_flags;
	logic        vga_off, cfg_rgb_order, cfg_565;
	logic [7:0]  vga_pal_a;
	logic [17:0] vga_pal_d;
	logic        vga_pal_we;

	logic        io_wait, bus_rd, bus_we, fb_en, fb_force_blank, fb_pal_wr;
	logic        led_hdd, led_fdd;
	logic [31:0] host_rdata, bus_addr, bus_wdata, fb_base;
	logic [11:0] fb_width, fb_height;
	logic [13:0] fb_stride;
	logic [4:0]  fb_format;
	logic [7:0]  fb_pal_addr;
	logic [23:0] fb_pal_dout;
	int          error_count;

	int          seed = 32'h0c94_b2d8;
	int          delay = 0;
	logic        pending = 1'b0;
	logic [31:0] word, data_word;
	logic [31:0] last_rdata = 32'h0;
	row_t        rows [N_ROWS];

	core_host_glue #(.led_hold_cycles(20)) uut (.*);

	core_monitor mon (.*);

	always #5 clk_sys = ~clk_sys;

	// ==============================
	// Bus responder model
	// ==============================

	always @(posedge clk_sys) begin
		if (cpu_reset) begin
			bus_wait <= 1'b0;
			bus_rdata_valid <= 1'b0;
			pending <= 1'b0;
			delay <= 0;
		end else begin
			word = $random(seed);
			data_word = $random(seed);
			bus_rdata_valid <= 1'b0;
			bus_wait <= (word[1:0] == 2'b00);
			if (bus_rd && !bus_wait) begin
				pending <= 1'b1;
				delay <= 1 + int'(word[15:8]) % 6;
			end else if (pending && delay > 1) begin
				delay <= delay - 1;
			end else if (pending) begin
				// Data beat always lands on an unstalled cycle
				pending <= 1'b0;
				bus_wait <= 1'b0;
				bus_rdata_valid <= 1'b1;
				bus_rdata <= data_word;
				last_rdata <= data_word;
			end
		end
	end

	task automatic wait_io_done();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (io_wait && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (io_wait)
			mon.note_failure("io_wait did not fall before the timeout");
	endtask

	task automatic wait_leds_off();
		int n;
		n = 0;
		while ((led_hdd || led_fdd) && n < LED_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (led_hdd || led_fdd)
			mon.note_failure("an activity LED stayed on past its hold time");
	endtask

	task automatic run_bus(input row_t r);
		@(posedge clk_sys);
		host_addr <= r.a;
		host_wdata <= r.d;
		disk_device <= r.dev;
		host_rd <= (r.kind == K_RD);
		host_wr <= (r.kind == K_WR);
		@(posedge clk_sys);
		host_rd <= 1'b0;
		host_wr <= 1'b0;
		wait_io_done();
		if (r.kind == K_RD)
			mon.check_read(last_rdata);
		else
			mon.check_write(r.a, r.d);
		wait_leds_off();
		mon.check_leds(r.dev);
	endtask

	task automatic run_desc(input row_t r);
		@(posedge clk_sys);
		vga_start_addr <= r.a[19:0];
		vga_width <= r.width;
		vga_stride <= r.stride;
		vga_height <= r.height;
		vga_flags <= r.flags;
		vga_off <= r.off;
		cfg_rgb_order <= r.rgb;
		cfg_565 <= r.c565;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		mon.check_desc(r.e_en, r.e_base, r.e_w, r.e_h, r.e_stride, r.e_fmt, r.off);
	endtask

	task automatic run_pal(input row_t r);
		@(posedge clk_sys);
		vga_pal_a <= r.a[7:0];
		vga_pal_d <= r.d[17:0];
		vga_pal_we <= 1'b1;
		@(negedge clk_sys);
		mon.check_pal(r.a[7:0], r.e_pal);
		@(posedge clk_sys);
		vga_pal_we <= 1'b0;
	endtask

	initial begin
		// Kind, stimulus, then expected descriptor or palette values
		rows[0] = '{K_RD, 32'h0000_1000, 32'h0, 1'b1, 9'd0, 9'd0, 11'd0, 4'h0, 1'b0, 1'b0,
			1'b0, 1'b0, 32'h0, 12'd0, 12'd0, 14'd0, 5'h0, 24'h0};
		rows[1] = '{K_RD, 32'h0000_2000, 32'h0, 1'b0, 9'd0, 9'd0, 11'd0, 4'h0, 1'b0, 1'b0,
			1'b0, 1'b0, 32'h0, 12'd0, 12'd0, 14'd0, 5'h0, 24'h0};
		rows[2] = '{K_WR, 32'h0000_3004, 32'hDEAD_BEEF, 1'b1, 9'd0, 9'd0, 11'd0, 4'h0, 1'b0,
			1'b0, 1'b0, 1'b0, 32'h0, 12'd0, 12'd0, 14'd0, 5'h0, 24'h0};
		rows[3] = '{K_WR, 32'h0000_4008, 32'h1234_5678, 1'b0, 9'd0, 9'd0, 11'd0, 4'h0, 1'b0,
			1'b0, 1'b0, 1'b0, 32'h0, 12'd0, 12'd0, 14'd0, 5'h0, 24'h0};
		rows[4] = '{K_DESC, 32'h12345, 32'h0, 1'b0, 9'd80, 9'd80, 11'd480, 4'b0001, 1'b0, 1'b0,
			1'b0, 1'b1, 32'h3F84_8D14, 12'd640, 12'd480, 14'd640, 5'h1B, 24'h0};
		rows[5] = '{K_DESC, 32'h00000, 32'h0, 1'b0, 9'd100, 9'd100, 11'd600, 4'b0010, 1'b0, 1'b1,
			1'b0, 1'b1, 32'h3F80_0000, 12'd800, 12'd600, 14'd800, 5'h0C, 24'h0};
		rows[6] = '{K_DESC, 32'hFFFFF, 32'h0, 1'b0, 9'd50, 9'd240, 11'd480, 4'b0011, 1'b0, 1'b0,
			1'b1, 1'b1, 32'h3FBF_FFFC, 12'd640, 12'd480, 14'd1920, 5'h15, 24'h0};
		rows[7] = '{K_DESC, 32'h00400, 32'h0, 1'b0, 9'd90, 9'd40, 11'd400, 4'b0101, 1'b1, 1'b1,
			1'b1, 1'b0, 32'h3F80_1000, 12'd360, 12'd400, 14'd320, 5'h03, 24'h0};
		rows[8] = '{K_DESC, 32'h0A000, 32'h0, 1'b0, 9'd64, 9'd64, 11'd800, 4'b1010, 1'b0, 1'b0,
			1'b0, 1'b1, 32'h3F82_8000, 12'd512, 12'd400, 14'd512, 5'h1C, 24'h0};
		rows[9] = '{K_PAL, 32'h5A, 32'h3F560, 1'b0, 9'd0, 9'd0, 11'd0, 4'h0, 1'b0, 1'b0,
			1'b0, 1'b0, 32'h0, 12'd0, 12'd0, 14'd0, 5'h0, 24'hFF5582};
		rows[10] = '{K_PAL, 32'h03, 32'h01A90, 1'b0, 9'd0, 9'd0, 11'd0, 4'h0, 1'b0, 1'b0,
			1'b0, 1'b0, 32'h0, 12'd0, 12'd0, 14'd0, 5'h0, 24'h04AA41};

		cpu_reset = 1'b1;
		host_rd = 1'b0;
		host_wr = 1'b0;
		host_addr = 32'h0;
		host_wdata = 32'h0;
		disk_device = 1'b0;
		vga_start_addr = 20'h0;
		vga_width = 9'd0;
		vga_stride = 9'd0;
		vga_height = 11'd0;
		// A mode that enables scan-out, so only reset keeps fb_en low
		vga_flags = 4'h1;
		vga_off = 1'b0;
		cfg_rgb_order = 1'b0;
		cfg_565 = 1'b0;
		vga_pal_a = 8'h0;
		vga_pal_d = 18'h0;
		vga_pal_we = 1'b0;

		repeat (4) @(posedge clk_sys);
		cpu_reset <= 1'b0;
		@(negedge clk_sys);
		mon.start_test("reset state");
		mon.check_reset();
		mon.end_test();

		for (int i = 0; i < N_ROWS; i++) begin
			case (rows[i].kind)
				K_RD: mon.start_test($sformatf("row %0d bridge read", i));
				K_WR: mon.start_test($sformatf("row %0d bridge write", i));
				K_DESC: mon.start_test($sformatf("row %0d descriptor", i));
				default: mon.start_test($sformatf("row %0d palette", i));
			endcase
			if (rows[i].kind == K_RD || rows[i].kind == K_WR)
				run_bus(rows[i]);
			else if (rows[i].kind == K_DESC)
				run_desc(rows[i]);
			else
				run_pal(rows[i]);
			mon.end_test();
		end

		repeat (2) @(posedge clk_sys);
		mon.report();
		if (error_count == 0 && uut.u_bridge.u_chk.fail_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/core_pkg.sv
hdl/activity_led.sv
hdl/mgmt_bridge.sv
hdl/framebuffer_config.sv
hdl/core_host_glue.sv
test/mgmt_bridge_chk.sv
test/core_monitor.sv
test/tb_core_host_glue.sv

// ==== Makefile ====
SIM       = verilator
TOP       = tb_core_host_glue
FILELIST  = tb.f
FLAGS     = --binary --timing --assert -j 0
RUN_FLAGS = +verilator+error+limit+100
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless the log shows a pass"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
